//--- fdd_geom_pkg.sv
`default_nettype none

package fdd_geom_pkg;

    // disk format, 720k style
    localparam int SECTORS     = 9;                      // per track side
    localparam int SECTOR_SIZE = 512;                    // bytes
    localparam int TRACKS      = 80;
    localparam int TRACK_BYTES = SECTORS * SECTOR_SIZE;  // 4608 per side

    localparam int TRACK_W = 7;   // head position width
    localparam int BUF_AW  = 13;  // track buffer address

    // mechanics, all in ms strobes
    localparam int MOTOR_DELAY   = 3;   // spin-up
    localparam int MOTOR_TIMEOUT = 30;  // run-on after MOTORn released
    localparam int STEP_SETTLE   = 3;   // head settle before track load

    localparam int BYTE_PERIOD = 568;  // clocks per byte on the disk surface

    typedef enum logic [1:0] {
        MOTOR_OFF,
        MOTOR_SPINUP,
        MOTOR_ON,
        MOTOR_RUNON
    } motor_state_t;

endpackage

`default_nettype wire

//--- sd_img_pkg.sv
`default_nettype none

package sd_img_pkg;

    localparam int LBA_W     = 32;  // sd_lba
    localparam int BLK_CNT_W = 6;   // sd_blk_cnt, blocks minus one
    localparam int SD_ADDR_W = 14;  // byte address within one request

    // one side of every track, anything bigger has a second side
    localparam logic [63:0] SS_IMAGE_BYTES =
        64'(fdd_geom_pkg::TRACKS * fdd_geom_pkg::TRACK_BYTES);

    // track loader sequence
    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_SETTLE,  // wait for head to settle
        LOAD_REQ,     // sd_rd up, waiting for ack
        LOAD_XFER     // card is filling the buffer
    } load_state_t;

endpackage

`default_nettype wire

//--- track_buf_if.sv
`default_nettype none

interface track_buf_if import fdd_geom_pkg::*; ();

    logic [BUF_AW-1:0]  buffer_addr;  // read address from transmitter
    logic [7:0]         buffer_q;     // registered RAM data
    logic               track_ready;  // buffer holds current track/side
    logic [TRACK_W-1:0] track;
    logic               side;

    // track loader owns the RAM and the head
    modport loader (
        input  buffer_addr,
        output buffer_q, track_ready, track, side
    );

    // byte stream side
    modport reader (
        output buffer_addr,
        input  buffer_q, track_ready, track, side
    );

endinterface

`default_nettype wire

//--- fdd_motor.sv
`default_nettype none

module fdd_motor import fdd_geom_pkg::*; (
    input  logic clk,
    input  logic msclk,     // 1 ms strobe
    input  logic rst,
    input  logic MOTORn,    // motor request, active low
    output logic motor_run  // spindle at speed
);

    motor_state_t state;
    logic [$clog2(MOTOR_TIMEOUT+1)-1:0] ms_cnt;  // spin-up and run-on share it

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= MOTOR_OFF;
            ms_cnt <= '0;
        end else begin
            case (state)
                MOTOR_OFF: begin
                    ms_cnt <= '0;
                    if (!MOTORn)
                        state <= MOTOR_SPINUP;
                end
                MOTOR_SPINUP: begin
                    if (MOTORn)
                        state <= MOTOR_OFF;  // released before up to speed
                    else if (msclk) begin
                        if (ms_cnt == MOTOR_DELAY - 1) begin
                            state  <= MOTOR_ON;
                            ms_cnt <= '0;
                        end else
                            ms_cnt <= ms_cnt + 1'b1;
                    end
                end
                MOTOR_ON: begin
                    ms_cnt <= '0;
                    if (MOTORn)
                        state <= MOTOR_RUNON;
                end
                MOTOR_RUNON: begin
                    // spindle still turning, a new request needs no spin-up
                    if (!MOTORn)
                        state <= MOTOR_ON;
                    else if (msclk) begin
                        if (ms_cnt == MOTOR_TIMEOUT - 1)
                            state <= MOTOR_OFF;
                        else
                            ms_cnt <= ms_cnt + 1'b1;
                    end
                end
                default: state <= MOTOR_OFF;
            endcase
        end
    end

    assign motor_run = (state == MOTOR_ON) || (state == MOTOR_RUNON);

endmodule

`default_nettype wire

//--- fdd_ready.sv
`default_nettype none

module fdd_ready import sd_img_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        motor_run,
    input  logic        img_mounted,   // strobe on image change
    input  logic        img_readonly,
    input  logic [63:0] img_size,      // bytes, zero means ejected
    output logic        READYn,
    output logic        WPROTn,
    output logic        sides          // 1 = double sided image
);

    logic disk_in;      // image present, latched at mount
    logic disk_in_now;  // mount strobe takes effect in its own clock
    logic ro_now;

    assign disk_in_now = img_mounted ? (img_size != 64'd0) : disk_in;
    assign ro_now      = img_mounted ? img_readonly : ~WPROTn;  // WPROTn doubles as ro flag

    always_ff @(posedge clk) begin
        if (rst) begin
            disk_in <= 1'b0;
            sides   <= 1'b0;
            READYn  <= 1'b1;
            WPROTn  <= 1'b1;
        end else begin
            if (img_mounted) begin
                disk_in <= (img_size != 64'd0);
                sides   <= (img_size > SS_IMAGE_BYTES);  // second side present
            end
            READYn <= ~(motor_run & disk_in_now);  // needs disk and spindle
            WPROTn <= ~(ro_now & disk_in_now);
        end
    end

endmodule

`default_nettype wire

//--- fdd_track.sv
`default_nettype none

module fdd_track import fdd_geom_pkg::*, sd_img_pkg::*; (
    input  logic                 clk,
    input  logic                 msclk,
    input  logic                 rst,
    input  logic                 READYn,
    input  logic                 sides,         // 1 = two sides in image
    input  logic                 STEPn,
    input  logic                 SDIRn,         // low = step in
    input  logic                 SIDEn,         // low = side 1
    input  logic                 sd_ack,
    input  logic                 sd_buff_wr,
    input  logic [SD_ADDR_W-1:0] sd_buff_addr,
    input  logic [7:0]           sd_buff_dout,
    output logic                 TRACK0n,
    output logic                 sd_rd,
    output logic [LBA_W-1:0]     sd_lba,
    output logic [BLK_CNT_W-1:0] sd_blk_cnt,
    track_buf_if.loader          tb
);

    logic               step_d;   // STEPn last clock
    logic               ready_d;
    logic [TRACK_W-1:0] track;    // head position
    logic [TRACK_W-1:0] track_d;
    logic               side_q;
    logic               side_d;
    logic               reload;   // buffer contents went stale
    logic               pending;  // reload seen while busy
    load_state_t        state;
    logic [$clog2(STEP_SETTLE+1)-1:0] settle_cnt;
    logic [LBA_W-1:0]   lba_next;
    logic               buf_we;
    logic [7:0]         ram [0:TRACK_BYTES-1];  // one track side

    // head movement
    always_ff @(posedge clk) begin
        if (rst) begin
            step_d  <= 1'b1;
            track   <= '0;
            track_d <= '0;
            side_q  <= 1'b0;
            side_d  <= 1'b0;
            ready_d <= 1'b1;
        end else begin
            step_d  <= STEPn;
            side_q  <= ~SIDEn;
            track_d <= track;
            side_d  <= side_q;
            ready_d <= READYn;
            if (step_d && !STEPn && !READYn) begin  // falling STEPn
                if (!SDIRn && track != TRACK_W'(TRACKS - 1))
                    track <= track + 1'b1;
                else if (SDIRn && track != '0)
                    track <= track - 1'b1;  // clamped at 0
            end
        end
    end

    assign TRACK0n = (track != '0);
    assign reload  = (track != track_d) || (side_q != side_d) || (ready_d && !READYn);

    // track-side-sector layout, side only counts on a two sided image
    assign lba_next = ((LBA_W'(track) << sides) + LBA_W'(side_q & sides))
                      * LBA_W'(SECTORS);
    assign sd_blk_cnt = BLK_CNT_W'(SECTORS - 1);

    // load sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= LOAD_IDLE;
            pending        <= 1'b0;
            settle_cnt     <= '0;
            sd_rd          <= 1'b0;
            sd_lba         <= '0;
            tb.track_ready <= 1'b0;
        end else begin
            if (reload || READYn)
                tb.track_ready <= 1'b0;  // drop at once
            if (reload)
                pending <= 1'b1;
            case (state)
                LOAD_IDLE: begin
                    if (pending && !READYn) begin
                        state      <= LOAD_SETTLE;
                        pending    <= 1'b0;
                        settle_cnt <= '0;
                    end
                end
                LOAD_SETTLE: begin
                    if (READYn) begin
                        state   <= LOAD_IDLE;  // resume when ready again
                        pending <= 1'b1;
                    end else if (reload) begin
                        settle_cnt <= '0;  // head moved again, restart
                        pending    <= 1'b0;
                    end else if (msclk) begin
                        if (settle_cnt == STEP_SETTLE - 1) begin
                            state  <= LOAD_REQ;
                            sd_rd  <= 1'b1;
                            sd_lba <= lba_next;  // stable until ack
                        end else
                            settle_cnt <= settle_cnt + 1'b1;
                    end
                end
                LOAD_REQ: begin
                    if (sd_ack) begin
                        sd_rd <= 1'b0;
                        state <= LOAD_XFER;
                    end
                end
                LOAD_XFER: begin
                    if (!sd_ack) begin
                        state <= LOAD_IDLE;
                        // a stale load goes round again from IDLE
                        if (!pending && !reload && !READYn)
                            tb.track_ready <= 1'b1;
                    end
                end
                default: state <= LOAD_IDLE;
            endcase
        end
    end

    assign buf_we = sd_ack && sd_buff_wr && (sd_buff_addr < SD_ADDR_W'(TRACK_BYTES));

    // track buffer, SD writes in, transmitter reads out
    always_ff @(posedge clk) begin
        if (buf_we)
            ram[sd_buff_addr[BUF_AW-1:0]] <= sd_buff_dout;
        tb.buffer_q <= ram[tb.buffer_addr];  // one clock read
    end

    assign tb.track = track;
    assign tb.side  = side_q;

endmodule

`default_nettype wire

//--- fdd_transmit.sv
`default_nettype none

module fdd_transmit import fdd_geom_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    track_buf_if.reader tb,
    output logic        INDEXn,         // low during byte 0
    output logic        data_valid,     // one clock per byte
    output logic [7:0]  data,
    output logic [11:0] curr_sec_info   // track, side, sector
);

    logic [$clog2(BYTE_PERIOD)-1:0]  div_cnt;   // byte rate divider
    logic                            rd_pend;   // RAM read in flight
    logic [BUF_AW-1:0]               byte_idx;  // rotating position
    logic [3:0]                      sec_num;
    logic [$clog2(SECTOR_SIZE)-1:0]  sec_off;   // byte within sector

    assign tb.buffer_addr = byte_idx;

    always_ff @(posedge clk) begin
        if (rst || !tb.track_ready) begin
            div_cnt    <= '0;
            rd_pend    <= 1'b0;
            byte_idx   <= '0;  // back to index on every reload
            sec_num    <= '0;
            sec_off    <= '0;
            INDEXn     <= 1'b1;
            data_valid <= 1'b0;
        end else begin
            data_valid <= 1'b0;
            rd_pend    <= 1'b0;
            if (div_cnt == BYTE_PERIOD - 1) begin
                div_cnt <= '0;
                rd_pend <= 1'b1;
            end else
                div_cnt <= div_cnt + 1'b1;

            if (rd_pend) begin  // buffer_q now holds byte_idx
                data_valid    <= 1'b1;
                INDEXn        <= (byte_idx != '0);
                curr_sec_info <= {tb.track, tb.side, sec_num};
                byte_idx <= (byte_idx == BUF_AW'(TRACK_BYTES - 1)) ? '0 : byte_idx + 1'b1;
                if (sec_off == SECTOR_SIZE - 1) begin
                    sec_off <= '0;
                    sec_num <= (sec_num == 4'(SECTORS - 1)) ? 4'd0 : sec_num + 4'd1;
                end else
                    sec_off <= sec_off + 1'b1;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (rd_pend)
            data <= tb.buffer_q;
    end

endmodule

`default_nettype wire

//--- fdd.sv
`default_nettype none

module fdd import sd_img_pkg::*; (
    input  logic                 clk,
    input  logic                 msclk,         // 1 ms strobe
    input  logic                 rst,

    // drive bus, active low
    input  logic                 MOTORn,
    input  logic                 STEPn,
    input  logic                 SDIRn,
    input  logic                 SIDEn,
    output logic                 READYn,
    output logic                 INDEXn,
    output logic                 TRACK0n,
    output logic                 WPROTn,

    // byte stream
    output logic [7:0]           data,
    output logic [11:0]          curr_sec_info,
    output logic                 data_valid,

    // mounted image
    input  logic                 img_mounted,
    input  logic                 img_readonly,
    input  logic [63:0]          img_size,

    // SD block access, read only
    output logic [LBA_W-1:0]     sd_lba,
    output logic [BLK_CNT_W-1:0] sd_blk_cnt,
    output logic                 sd_rd,
    input  logic                 sd_ack,
    input  logic [SD_ADDR_W-1:0] sd_buff_addr,
    input  logic [7:0]           sd_buff_dout,
    input  logic                 sd_buff_wr
);

    logic motor_run;
    logic sides;

    track_buf_if tbuf ();  // loader to transmitter

    fdd_motor u_motor (
        .clk       (clk),
        .msclk     (msclk),
        .rst       (rst),
        .MOTORn    (MOTORn),
        .motor_run (motor_run)
    );

    fdd_ready u_ready (
        .clk          (clk),
        .rst          (rst),
        .motor_run    (motor_run),
        .img_mounted  (img_mounted),
        .img_readonly (img_readonly),
        .img_size     (img_size),
        .READYn       (READYn),
        .WPROTn       (WPROTn),
        .sides        (sides)
    );

    fdd_track u_track (
        .clk          (clk),
        .msclk        (msclk),
        .rst          (rst),
        .READYn       (READYn),
        .sides        (sides),
        .STEPn        (STEPn),
        .SDIRn        (SDIRn),
        .SIDEn        (SIDEn),
        .sd_ack       (sd_ack),
        .sd_buff_wr   (sd_buff_wr),
        .sd_buff_addr (sd_buff_addr),
        .sd_buff_dout (sd_buff_dout),
        .TRACK0n      (TRACK0n),
        .sd_rd        (sd_rd),
        .sd_lba       (sd_lba),
        .sd_blk_cnt   (sd_blk_cnt),
        .tb           (tbuf.loader)
    );

    fdd_transmit u_transmit (
        .clk           (clk),
        .rst           (rst),
        .tb            (tbuf.reader),
        .INDEXn        (INDEXn),
        .data_valid    (data_valid),
        .data          (data),
        .curr_sec_info (curr_sec_info)
    );

endmodule

`default_nettype wire

//--- tb_fdd.sv
`default_nettype none

module tb_fdd import fdd_geom_pkg::*, sd_img_pkg::*; ();

    localparam int MS_CLOCKS  = 50;     // clocks per msclk pulse
    localparam int WAIT_LIMIT = 20000;  // longest single wait in clocks
    localparam int N_ROWS     = 8;
    localparam int N_BYTES    = 16;     // bytes checked per load

    // one head move and the load it should cause
    typedef struct packed {
        int   steps;
        logic dir;    // SDIRn level where 0 steps in
        logic side;
        logic ds;     // image double sided
        int   track;  // after clamp
        int   lba;
    } row_t;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 msclk = 1'b0;
    logic                 MOTORn, STEPn, SDIRn, SIDEn;
    logic                 READYn, INDEXn, TRACK0n, WPROTn;
    logic [7:0]           data;
    logic [11:0]          curr_sec_info;
    logic                 data_valid;
    logic                 img_mounted, img_readonly;
    logic [63:0]          img_size;
    logic [LBA_W-1:0]     sd_lba;
    logic [BLK_CNT_W-1:0] sd_blk_cnt;
    logic                 sd_rd;
    logic                 sd_ack = 1'b0;
    logic [SD_ADDR_W-1:0] sd_buff_addr = '0;
    logic [7:0]           sd_buff_dout = '0;
    logic                 sd_buff_wr = 1'b0;

    int   ms_div = 0;
    int   ms_total = 0;  // msclk pulses since reset
    int   checks = 0;
    int   errors = 0;
    int   tests = 0;
    row_t rows [0:N_ROWS-1];

    fdd u_fdd (.*);

    always #2 clk = ~clk;

    // 1 ms strobe
    always @(posedge clk) begin
        if (rst) begin
            ms_div <= 0;
            msclk  <= 1'b0;
        end else begin
            msclk  <= (ms_div == MS_CLOCKS - 1);
            ms_div <= (ms_div == MS_CLOCKS - 1) ? 0 : ms_div + 1;
            if (ms_div == MS_CLOCKS - 1)
                ms_total <= ms_total + 1;
        end
    end

    // SD card model writes the low byte of lba plus address
    always begin : sd_card
        logic [LBA_W-1:0] lba_q;
        @(negedge clk);
        if (sd_rd === 1'b1) begin
            lba_q = sd_lba;  // still stable until ack
            @(posedge clk);
            sd_ack <= 1'b1;
            for (int i = 0; i < TRACK_BYTES; i++) begin
                @(posedge clk);
                sd_buff_wr   <= 1'b1;
                sd_buff_addr <= SD_ADDR_W'(i);
                sd_buff_dout <= 8'(lba_q + i);
            end
            @(posedge clk);
            sd_buff_wr <= 1'b0;
            sd_ack     <= 1'b0;  // end of transfer
        end
    end

    function automatic row_t make_row(input int steps, input logic dir, input logic side,
                                      input logic ds, input int track, input int lba);
        row_t r;
        r.steps = steps;
        r.dir   = dir;
        r.side  = side;
        r.ds    = ds;
        r.track = track;
        r.lba   = lba;
        return r;
    endfunction

    task automatic check_eq(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_near(input string name, input int got, input int exp, input int tol);
        checks++;
        assert (got >= exp - tol && got <= exp + tol) else begin
            $display("FAIL t=%0t %s got %0d expected %0d +-%0d", $time, name, got, exp, tol);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("test %s done, %0d errors", name, errors - err_before);
    endtask

    task automatic give_up(input string what);
        $display("timeout: %s did not happen in %0d clocks", what, WAIT_LIMIT);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic wait_ready(input logic level);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (READYn !== level && n < WAIT_LIMIT);
        if (READYn !== level)
            give_up("READYn change");
    endtask

    task automatic wait_sd_rd();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (sd_rd !== 1'b1 && n < WAIT_LIMIT);
        if (sd_rd !== 1'b1)
            give_up("sd_rd request");
    endtask

    task automatic wait_byte();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (data_valid !== 1'b1 && n < WAIT_LIMIT);
        if (data_valid !== 1'b1)
            give_up("data_valid strobe");
    endtask

    // one clock mount pulse
    task automatic mount(input logic ds, input logic ro);
        @(posedge clk);
        img_mounted  <= 1'b1;
        img_readonly <= ro;
        img_size     <= ds ? SS_IMAGE_BYTES * 2 : SS_IMAGE_BYTES;  // exact size = single
        @(posedge clk);
        img_mounted  <= 1'b0;
    endtask

    task automatic step_head(input int n, input logic dir);
        @(posedge clk);
        SDIRn <= dir;
        repeat (n) begin
            @(posedge clk);
            STEPn <= 1'b0;  // falling edge moves the head
            @(posedge clk);
            @(posedge clk);
            STEPn <= 1'b1;
            @(posedge clk);
        end
    endtask

    initial begin
        int t0;
        int err0;
        logic cur_ds;

        rst          = 1'b1;
        MOTORn       = 1'b1;
        STEPn        = 1'b1;
        SDIRn        = 1'b1;
        SIDEn        = 1'b1;
        img_mounted  = 1'b0;
        img_readonly = 1'b0;
        img_size     = '0;

        // expected lba is (track * sides + side) * 9 with side counted on two sides only
        rows[0] = make_row(0,  1'b0, 1'b0, 1'b1, 0,  0);     // load after spin-up
        rows[1] = make_row(5,  1'b0, 1'b0, 1'b1, 5,  90);
        rows[2] = make_row(0,  1'b0, 1'b1, 1'b1, 5,  99);    // side change only
        rows[3] = make_row(8,  1'b1, 1'b1, 1'b1, 0,  9);     // past track 0
        rows[4] = make_row(85, 1'b0, 1'b0, 1'b1, 79, 1422);  // past last track
        rows[5] = make_row(3,  1'b1, 1'b1, 1'b1, 76, 1377);
        rows[6] = make_row(2,  1'b0, 1'b1, 1'b0, 78, 702);   // single sided image on side 1
        rows[7] = make_row(4,  1'b0, 1'b0, 1'b0, 79, 711);

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // reset values
        err0 = errors;
        @(negedge clk);
        check_eq("READYn", READYn, 1);
        check_eq("INDEXn", INDEXn, 1);
        check_eq("WPROTn", WPROTn, 1);
        check_eq("sd_rd", sd_rd, 0);
        check_eq("data_valid", data_valid, 0);
        check_eq("TRACK0n", TRACK0n, 0);
        end_test("reset", err0);

        // spin-up and run-on timing
        err0 = errors;
        mount(1'b1, 1'b1);
        repeat (2) @(negedge clk);
        check_eq("WPROTn", WPROTn, 0);
        check_eq("READYn", READYn, 1);  // motor still off
        @(posedge clk);
        MOTORn <= 1'b0;
        t0 = ms_total;
        wait_ready(1'b0);
        check_near("spin-up ms", ms_total - t0, MOTOR_DELAY, 1);
        @(posedge clk);
        MOTORn <= 1'b1;
        t0 = ms_total;
        wait_ready(1'b1);
        check_near("run-on ms", ms_total - t0, MOTOR_TIMEOUT, 1);
        @(posedge clk);
        MOTORn <= 1'b0;  // stays on for the table
        end_test("motor", err0);

        cur_ds = 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            err0 = errors;
            if (rows[r].ds != cur_ds) begin
                mount(rows[r].ds, rows[r].ds);  // single sided images are writable
                cur_ds = rows[r].ds;
                repeat (2) @(negedge clk);
                check_eq("WPROTn", WPROTn, !rows[r].ds);
            end
            @(posedge clk);
            SIDEn <= ~rows[r].side;  // active low
            if (rows[r].steps > 0)
                step_head(rows[r].steps, rows[r].dir);
            wait_sd_rd();
            check_eq("sd_lba", sd_lba, rows[r].lba);
            check_eq("sd_blk_cnt", sd_blk_cnt, SECTORS - 1);
            check_eq("TRACK0n", TRACK0n, rows[r].track != 0);
            for (int k = 0; k < N_BYTES; k++) begin
                wait_byte();
                check_eq("data", data, (rows[r].lba + k) & 8'hff);
                check_eq("curr_sec_info", curr_sec_info,
                         (rows[r].track << 5) | (rows[r].side << 4));  // sector 0
                check_eq("INDEXn", INDEXn, k != 0);
            end
            end_test($sformatf("row %0d", r), err0);
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
fdd_geom_pkg.sv
sd_img_pkg.sv
track_buf_if.sv
fdd_motor.sv
fdd_ready.sv
fdd_track.sv
fdd_transmit.sv
fdd.sv
tb_fdd.sv
